// File: exec_unit.f
+incdir+include
logic/exec_pkg.sv
logic/op_decoder.sv
logic/alu_lsb.sv
logic/alu_mid.sv
logic/alu_msb.sv
logic/alu.sv
logic/exec_unit.sv
dv/tb_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the exec_unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f exec_unit.f --top-module tb_exec_unit -o tb_exec_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: include/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic is_illegal_instr(rv_instr_u instr);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_imm;
    logic       is_word;
    opc     = instr.r_view.opcode;
    f3      = instr.r_view.funct3;
    f7      = instr.r_view.funct7;
    is_imm  = (opc == OPC_OP_IMM) || (opc == OPC_OP_IMM_32);
    is_word = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
    if (!(opc inside {OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32})) return 1'b1;
    if (is_word && !(f3 inside {F3_ADD, F3_SLL, F3_SR})) return 1'b1;
    if (is_imm) begin
        if (f3 == F3_SLL) return is_word ? (f7 != 7'h00) : (f7[6:1] != 6'h00);
        if (f3 == F3_SR) begin
            return is_word ? !(f7 inside {7'h00, 7'h20}) : !(f7[6:1] inside {6'h00, 6'h10});
        end
        return 1'b0;
    end
    if (f3 == F3_ADD || f3 == F3_SR) return !(f7 inside {7'h00, 7'h20});
    return f7 != 7'h00;
endfunction

function automatic exec_rsp_t predict_response(exec_req_t req);
    exec_rsp_t   rsp;
    logic [2:0]  f3;
    logic        is_imm;
    logic        is_word;
    logic        alt;
    logic [63:0] a;
    logic [63:0] b;
    logic [64:0] sum;
    logic [64:0] diff;
    logic [31:0] w;
    rsp     = '0;
    f3      = req.instr.r_view.funct3;
    is_imm  = req.instr.r_view.opcode inside {OPC_OP_IMM, OPC_OP_IMM_32};
    is_word = req.instr.r_view.opcode inside {OPC_OP_32, OPC_OP_IMM_32};
    alt     = req.instr.r_view.funct7[5];
    a       = req.rs1_val;
    b       = is_imm ? {{52{req.instr.i_view.imm[11]}}, req.instr.i_view.imm} : req.rs2_val;
    sum     = {1'b0, a} + {1'b0, b};
    diff    = {1'b0, a} + {1'b0, ~b} + 65'd1;
    if (is_illegal_instr(req.instr)) begin
        rsp.illegal = 1'b1;
        return rsp;
    end
    case (f3)
        F3_ADD:  {rsp.cout, rsp.result} = (alt && !is_imm) ? diff : sum;
        F3_SLT:  {rsp.cout, rsp.result} = {diff[64], 63'd0, $signed(a) < $signed(b)};
        F3_SLTU: {rsp.cout, rsp.result} = {diff[64], 63'd0, a < b};
        F3_XOR:  rsp.result = a ^ b;
        F3_OR:   rsp.result = a | b;
        F3_AND:  rsp.result = a & b;
        F3_SLL:  rsp.result = is_word ? {32'd0, a[31:0] << b[4:0]} : a << b[5:0];
        default: begin
            // Arithmetic right shift as a logical shift with the sign filled in
            if (is_word) begin
                w = (a[31:0] >> b[4:0])
                  | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
                rsp.result = {32'd0, w};
            end else begin
                rsp.result = (a >> b[5:0])
                           | ((alt && a[63]) ? ~({64{1'b1}} >> b[5:0]) : 64'd0);
            end
        end
    endcase
    if (is_word) rsp.result = {{32{rsp.result[31]}}, rsp.result[31:0]};
    return rsp;
endfunction

`endif

// File: dv/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit import exec_pkg::*; ();

    `include "exec_model.svh"

    localparam int NUM_INSTR   = 2000;
    localparam int CYCLE_LIMIT = 4000;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        exec_rsp_t   rsp;
        logic [31:0] due;
    } sb_entry_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    exec_req_t in_req;
    logic      out_valid;
    exec_rsp_t out_rsp;

    integer    seed;
    int        cycle;
    int        sent;
    sb_entry_t exp_q[$];

    exec_unit i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input logic [95:0] actual, input logic [95:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL at time %0t: %s, got %0h, expected %0h",
                                    $time, what, actual, expected));
        end
    endtask

    // Sign boundaries, all ones and 32-bit overflow values come up often
    function automatic logic [63:0] pick_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        case (hi[2:0])
            3'd0:    return '1;
            3'd1:    return 64'h8000_0000_0000_0000;
            3'd2:    return 64'h7fff_ffff_ffff_ffff;
            3'd3:    return {hi, 32'h7fff_ffff};
            3'd4:    return {hi, 32'h8000_0000};
            default: return {hi, lo};
        endcase
    endfunction

    function automatic exec_req_t make_request();
        exec_req_t   req;
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        r  = $random(seed);
        r2 = $random(seed);
        case (r[2:0])
            3'd0, 3'd1: opc = OPC_OP;
            3'd2, 3'd3: opc = OPC_OP_IMM;
            3'd4:       opc = OPC_OP_32;
            3'd5:       opc = OPC_OP_IMM_32;
            3'd6:       opc = r[3] ? OPC_OP_32 : OPC_OP_IMM_32;
            default:    opc = r[31:25];
        endcase
        f3 = r[6:4];
        // Word forms mostly take add or a shift
        if (opc inside {OPC_OP_32, OPC_OP_IMM_32} && r[9:8] != 2'd3) begin
            f3 = (r[9:8] == 2'd0) ? F3_ADD : (r[9:8] == 2'd1) ? F3_SLL : F3_SR;
        end
        case (r[12:10])
            3'd0, 3'd1, 3'd2: f7 = 7'h00;
            3'd3, 3'd4:       f7 = 7'h20;
            3'd5:             f7 = 7'h01;
            default:          f7 = r[22:16];
        endcase
        // imm[5] reaches shift amounts of 32 and up
        if (opc == OPC_OP_IMM && f7 inside {7'h00, 7'h20}) begin
            f7[0] = r[23];
        end
        if (opc inside {OPC_OP_IMM, OPC_OP_IMM_32} && !(f3 inside {F3_SLL, F3_SR}) && r[24]) begin
            f7 = r[31:25];
        end
        req.instr.r_view = '{f7, r2[4:0], r2[9:5], f3, r2[14:10], opc};
        req.rs1_val      = pick_operand();
        req.rs2_val      = (r2[17:16] == 2'd0) ? req.rs1_val : pick_operand();
        return req;
    endfunction

    // Outputs are sampled on the falling edge away from the register updates
    task automatic next_cycle();
        sb_entry_t entry;
        @(negedge clk);
        cycle++;
        if (out_valid) begin
            check_equal(exp_q.size() != 0, 1'b1, "out_valid with no request in flight");
            entry = exp_q.pop_front();
            check_equal(cycle, entry.due, "response cycle");
            check_equal(out_rsp, entry.rsp, "response result, cout and illegal");
        end else if (exp_q.size() != 0) begin
            check_equal(exp_q[0].due > cycle, 1'b1, "out_valid missing at its cycle");
        end
    endtask

    initial begin
        exec_req_t   req;
        sb_entry_t   entry;
        logic [31:0] r;
        int          waited;
        seed     = 65458;
        cycle    = 0;
        sent     = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (4) begin
            next_cycle();
            check_equal(out_valid, 1'b0, "out_valid during reset");
        end
        rst_n = 1'b1;
        while (sent < NUM_INSTR) begin
            next_cycle();
            if (cycle > CYCLE_LIMIT) begin
                stop_on_error("Timed out before all requests were sent");
            end
            r        = $random(seed);
            req      = make_request();
            in_req   = req;
            in_valid = (r % 100) < 70;
            if (in_valid) begin
                entry.rsp = predict_response(req);
                entry.due = cycle + 2;
                exp_q.push_back(entry);
                sent++;
            end
        end
        // The last request is held until the clock edge takes it
        next_cycle();
        in_valid = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_on_error("Timed out waiting for the last responses");
            end
        end
        // A few idle cycles catch stray responses
        repeat (4) next_cycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  exec_req_t in_req,
    output logic      out_valid,
    output exec_rsp_t out_rsp
);

    alu_ctrl_t   dec_ctrl;
    alu_ctrl_t   s1_ctrl;
    logic        s1_valid;
    logic [63:0] alu_result;
    logic        alu_cout;

    op_decoder u_dec (
        .req  (in_req),
        .ctrl (dec_ctrl)
    );

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_ctrl <= dec_ctrl;
        end
    end

    alu u_alu (
        .alu_op      (s1_ctrl.op),
        .input_alu_a (s1_ctrl.opa),
        .input_alu_b (s1_ctrl.opb),
        .is_32bit    (s1_ctrl.is_32bit),
        .alu_result  (alu_result),
        .alu_cout    (alu_cout)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_rsp   <= '0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
            if (s1_valid) begin
                // Illegal entries leave with a zero result
                out_rsp.result  <= s1_ctrl.illegal ? 64'd0 : alu_result;
                out_rsp.cout    <= s1_ctrl.illegal ? 1'b0 : alu_cout;
                out_rsp.illegal <= s1_ctrl.illegal;
            end
        end
    end

    a_latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##2 out_valid)
        else $error("out_valid missing two cycles after in_valid");

    a_latency_bwd: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2))
        else $error("out_valid without a request two cycles earlier");

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_valid && !s1_ctrl.illegal) |-> s1_ctrl.op inside
            {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
             ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA})
        else $error("unused ALU op code in stage 1");

    // Logic and shift ops never carry out of the chain
    a_cout_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_valid && s1_ctrl.op inside {ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA})
            |=> !out_rsp.cout)
        else $error("carry out set for a logic or shift op");

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  alu_op_e     alu_op,
    input  logic [63:0] input_alu_a,
    input  logic [63:0] input_alu_b,
    input  logic        is_32bit,
    output logic [63:0] alu_result,
    output logic        alu_cout
);

    logic [62:0] carry_chain;
    logic [63:0] slice_result;
    logic [63:0] shift_result;
    logic [31:0] a_32;
    logic [31:0] sll_32;
    logic [31:0] srl_32;
    logic [31:0] sra_32;
    logic [31:0] word_32;

    alu_lsb u_lsb (
        .alu_op      (alu_op),
        .input_alu_a (input_alu_a[0]),
        .input_alu_b (input_alu_b[0]),
        .alu_result  (slice_result[0]),
        .alu_cout    (carry_chain[0])
    );

    for (genvar i = 1; i < 63; i++) begin : g_mid
        alu_mid u_mid (
            .alu_op      (alu_op),
            .input_alu_a (input_alu_a[i]),
            .input_alu_b (input_alu_b[i]),
            .cin         (carry_chain[i-1]),
            .alu_result  (slice_result[i]),
            .alu_cout    (carry_chain[i])
        );
    end

    alu_msb u_msb (
        .alu_op      (alu_op),
        .input_alu_a (input_alu_a[63]),
        .input_alu_b (input_alu_b[63]),
        .cin         (carry_chain[62]),
        .alu_result  (slice_result[63]),
        .alu_cout    (alu_cout)
    );

    // 64-bit shifts take six bits of B
    always_comb begin
        case (alu_op)
            ALU_SLL: shift_result = input_alu_a << input_alu_b[5:0];
            ALU_SRL: shift_result = input_alu_a >> input_alu_b[5:0];
            default: shift_result = $signed(input_alu_a) >>> input_alu_b[5:0];
        endcase
    end

    // Word paths, the low half of the chain already holds ADDW and SUBW
    assign a_32   = input_alu_a[31:0];
    assign sll_32 = a_32 << input_alu_b[4:0];
    assign srl_32 = a_32 >> input_alu_b[4:0];
    assign sra_32 = $signed(a_32) >>> input_alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SLL: word_32 = sll_32;
            ALU_SRL: word_32 = srl_32;
            ALU_SRA: word_32 = sra_32;
            default: word_32 = slice_result[31:0];
        endcase
    end

    always_comb begin
        if (is_32bit) begin
            alu_result = {{32{word_32[31]}}, word_32};
        end else begin
            case (alu_op)
                ALU_SLL, ALU_SRL, ALU_SRA: alu_result = shift_result;
                ALU_SLT, ALU_SLTU:         alu_result = {63'b0, slice_result[63]};
                default:                   alu_result = slice_result;
            endcase
        end
    end

endmodule

// File: logic/alu_msb.sv
`timescale 1ns/1ps

module alu_msb import exec_pkg::*; (
    input  alu_op_e alu_op,
    input  logic    input_alu_a,
    input  logic    input_alu_b,
    input  logic    cin,
    output logic    alu_result,
    output logic    alu_cout
);

    logic sub;
    logic arith;
    logic b_eff;
    logic sum;
    logic carry;
    logic overflow;
    logic lt_signed;
    logic lt_unsigned;

    assign sub   = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign arith = sub || (alu_op == ALU_ADD);
    assign b_eff = input_alu_b ^ sub;
    assign sum   = input_alu_a ^ b_eff ^ cin;
    assign carry = (input_alu_a & b_eff) | (cin & (input_alu_a ^ b_eff));

    // Signed overflow when carry into and out of the sign bit differ
    assign overflow    = cin ^ carry;
    assign lt_signed   = sum ^ overflow;
    assign lt_unsigned = ~carry;

    always_comb begin
        case (alu_op)
            ALU_AND:  alu_result = input_alu_a & input_alu_b;
            ALU_OR:   alu_result = input_alu_a | input_alu_b;
            ALU_XOR:  alu_result = input_alu_a ^ input_alu_b;
            ALU_SLT:  alu_result = lt_signed;
            ALU_SLTU: alu_result = lt_unsigned;
            default:  alu_result = sum;
        endcase
    end

    assign alu_cout = arith & carry;

endmodule

// File: logic/alu_mid.sv
`timescale 1ns/1ps

module alu_mid import exec_pkg::*; (
    input  alu_op_e alu_op,
    input  logic    input_alu_a,
    input  logic    input_alu_b,
    input  logic    cin,
    output logic    alu_result,
    output logic    alu_cout
);

    logic sub;
    logic arith;
    logic b_eff;

    assign sub   = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign arith = sub || (alu_op == ALU_ADD);
    assign b_eff = input_alu_b ^ sub;

    always_comb begin
        case (alu_op)
            ALU_AND: alu_result = input_alu_a & input_alu_b;
            ALU_OR:  alu_result = input_alu_a | input_alu_b;
            ALU_XOR: alu_result = input_alu_a ^ input_alu_b;
            default: alu_result = input_alu_a ^ b_eff ^ cin;
        endcase
    end

    // Carry stays low through logic and shift ops
    assign alu_cout = arith & ((input_alu_a & b_eff) | (cin & (input_alu_a ^ b_eff)));

endmodule

// File: logic/alu_lsb.sv
`timescale 1ns/1ps

module alu_lsb import exec_pkg::*; (
    input  alu_op_e alu_op,
    input  logic    input_alu_a,
    input  logic    input_alu_b,
    output logic    alu_result,
    output logic    alu_cout
);

    logic sub;
    logic arith;
    logic b_eff;
    logic sum;

    // Subtract and compares add the inverted B plus one
    assign sub   = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign arith = sub || (alu_op == ALU_ADD);
    assign b_eff = input_alu_b ^ sub;
    assign sum   = input_alu_a ^ b_eff ^ sub;

    always_comb begin
        case (alu_op)
            ALU_AND: alu_result = input_alu_a & input_alu_b;
            ALU_OR:  alu_result = input_alu_a | input_alu_b;
            ALU_XOR: alu_result = input_alu_a ^ input_alu_b;
            default: alu_result = sum;
        endcase
    end

    assign alu_cout = arith & ((input_alu_a & b_eff) | (sub & (input_alu_a ^ b_eff)));

endmodule

// File: logic/op_decoder.sv
`timescale 1ns/1ps

module op_decoder import exec_pkg::*; (
    input  exec_req_t req,
    output alu_ctrl_t ctrl
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm;
    logic        is_imm;
    logic        is_word;
    logic        known_opc;
    logic        bad_funct;
    alu_op_e     op;

    // Register fields and the immediate share the upper bits of the word
    assign opcode = req.instr.r_view.opcode;
    assign funct3 = req.instr.r_view.funct3;
    assign funct7 = req.instr.r_view.funct7;
    assign imm    = req.instr.i_view.imm;

    assign is_imm    = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);
    assign is_word   = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);
    assign known_opc = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || is_word;

    always_comb begin
        case (funct3)
            // No SUBI, so the alternate bit only counts for registers
            F3_ADD:  op = (!is_imm && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    always_comb begin
        bad_funct = 1'b0;
        if (is_imm) begin
            // Shift amount field is 6 bits wide for 64-bit shifts, 5 for word
            if (funct3 == F3_SLL) begin
                bad_funct = is_word ? (imm[11:5] != 7'b0000000)
                                    : (imm[11:6] != 6'b000000);
            end else if (funct3 == F3_SR) begin
                bad_funct = is_word ? !(imm[11:5] inside {7'b0000000, 7'b0100000})
                                    : !(imm[11:6] inside {6'b000000, 6'b010000});
            end
        end else if (funct3 == F3_ADD || funct3 == F3_SR) begin
            bad_funct = !(funct7 inside {7'b0000000, 7'b0100000});
        end else begin
            bad_funct = (funct7 != 7'b0000000);
        end
        // Word forms exist only for add, sub and shifts
        if (is_word && !(funct3 inside {F3_ADD, F3_SLL, F3_SR})) begin
            bad_funct = 1'b1;
        end
    end

    always_comb begin
        ctrl.op       = op;
        ctrl.is_32bit = is_word;
        ctrl.illegal  = !known_opc || bad_funct;
        ctrl.opa      = req.rs1_val;
        ctrl.opb      = is_imm ? {{52{imm[11]}}, imm} : req.rs2_val;
    end

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

    // ALU operation codes, 5 to 10 are unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd11,
        ALU_SLTU = 4'd12,
        ALU_SLL  = 4'd13,
        ALU_SRL  = 4'd14,
        ALU_SRA  = 4'd15
    } alu_op_e;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    // funct3 of the integer ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } rv_instr_u;

    typedef struct packed {
        rv_instr_u   instr;
        logic [63:0] rs1_val;
        logic [63:0] rs2_val;
    } exec_req_t;

    typedef struct packed {
        alu_op_e     op;
        logic        is_32bit;
        logic        illegal;
        logic [63:0] opa;
        logic [63:0] opb;
    } alu_ctrl_t;

    typedef struct packed {
        logic [63:0] result;
        logic        cout;
        logic        illegal;
    } exec_rsp_t;

endpackage
